/* common/cdma_pkg.sv */
/* cdma package
   widths, register map and request/response types shared by the copy engine blocks */
package cdma_pkg;

  localparam int DATA_W       = 32;
  localparam int ADDR_W       = 16;  // word address
  localparam int BANK_W       = 3;
  localparam int OFS_W        = 13;
  localparam int NUM_BANKS    = 6;
  localparam int LEN_W        = 14;  // up to 8192 words
  localparam int MAX_INFLIGHT = 2;
  localparam int INFL_W       = $clog2(MAX_INFLIGHT + 1);
  localparam int INFL_PTR_W   = $clog2(MAX_INFLIGHT);

  localparam int REG_ADDR_W = 3;
  localparam logic [REG_ADDR_W-1:0] REG_SRC    = 3'd0;
  localparam logic [REG_ADDR_W-1:0] REG_DST    = 3'd1;
  localparam logic [REG_ADDR_W-1:0] REG_LEN    = 3'd2;
  localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 3'd3;  // bit 0 starts a copy
  localparam logic [REG_ADDR_W-1:0] REG_STATUS = 3'd4;

  typedef struct packed {
    logic [BANK_W-1:0] bank;
    logic [OFS_W-1:0]  ofs;
  } gmem_split_t;

  typedef union packed {
    logic [ADDR_W-1:0] flat;   // engine view
    gmem_split_t       split;  // router view
  } gmem_addr_u;

  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
  } reg_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;  // zero for writes
  } reg_rsp_t;

  typedef struct packed {
    logic              we;
    gmem_addr_u        addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic              we;
    logic [OFS_W-1:0]  ofs;
    logic [DATA_W-1:0] wdata;
  } bank_req_t;

  typedef struct packed {
    logic busy;
    logic done;
    logic err;
  } status_t;

endpackage

/* hw/ctrl_regs/ctrl_regs.sv */
/* ctrl_regs
   register slave holding copy source, destination, length and status */
`timescale 1ns/1ns

module ctrl_regs (
  input  logic                        ap_clk,
  input  logic                        arst_n,
  input  cdma_pkg::reg_req_t          reg_req,
  input  logic                        reg_req_valid,
  output logic                        reg_req_ready,
  output cdma_pkg::reg_rsp_t          reg_rsp,
  output logic                        reg_rsp_valid,
  input  logic                        reg_rsp_ready,
  output logic                        start,
  output cdma_pkg::gmem_addr_u        src,
  output cdma_pkg::gmem_addr_u        dst,
  output logic [cdma_pkg::LEN_W-1:0]  len,
  input  logic                        done
);

  cdma_pkg::status_t status;
  logic              req_fire;
  logic              ctrl_wr;
  logic              ranges_ok;

  // last word must not wrap and must land in a populated bank
  function automatic logic range_ok(cdma_pkg::gmem_addr_u base,
                                    logic [cdma_pkg::LEN_W-1:0] n);
    logic [cdma_pkg::ADDR_W:0] sum;
    cdma_pkg::gmem_addr_u      last;
    sum       = {1'b0, base.flat} + (cdma_pkg::ADDR_W + 1)'(n) - (cdma_pkg::ADDR_W + 1)'(1);
    last.flat = sum[cdma_pkg::ADDR_W-1:0];
    return !sum[cdma_pkg::ADDR_W] &&
           (last.split.bank < cdma_pkg::BANK_W'(cdma_pkg::NUM_BANKS));
  endfunction

  assign reg_req_ready = !reg_rsp_valid;  // one access at a time
  assign req_fire      = reg_req_valid && reg_req_ready;
  assign ctrl_wr       = req_fire && reg_req.we && (reg_req.addr == cdma_pkg::REG_CTRL);
  assign ranges_ok     = (len != '0) && range_ok(src, len) && range_ok(dst, len);

  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_rsp_valid <= 1'b0;
      start         <= 1'b0;
      status        <= '0;
      src           <= '0;
      dst           <= '0;
      len           <= '0;
    end else begin
      start <= 1'b0;
      if (req_fire) begin
        reg_rsp_valid <= 1'b1;
      end else if (reg_rsp_ready) begin
        reg_rsp_valid <= 1'b0;
      end
      if (req_fire && reg_req.we) begin
        case (reg_req.addr)
          cdma_pkg::REG_SRC: src.flat <= reg_req.wdata[cdma_pkg::ADDR_W-1:0];
          cdma_pkg::REG_DST: dst.flat <= reg_req.wdata[cdma_pkg::ADDR_W-1:0];
          cdma_pkg::REG_LEN: len      <= reg_req.wdata[cdma_pkg::LEN_W-1:0];
          default: ;
        endcase
      end
      if (ctrl_wr) begin
        status.done <= 1'b0;
        status.err  <= 1'b0;
        if (reg_req.wdata[0] && !status.busy) begin  // ignored while busy
          if (ranges_ok) begin
            start       <= 1'b1;
            status.busy <= 1'b1;
          end else begin
            status.err <= 1'b1;
          end
        end
      end
      if (done) begin  // end of copy wins over a clear
        status.busy <= 1'b0;
        status.done <= 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (req_fire) begin
      reg_rsp.rdata <= '0;
      if (!reg_req.we) begin
        case (reg_req.addr)
          cdma_pkg::REG_SRC:    reg_rsp.rdata <= cdma_pkg::DATA_W'(src.flat);
          cdma_pkg::REG_DST:    reg_rsp.rdata <= cdma_pkg::DATA_W'(dst.flat);
          cdma_pkg::REG_LEN:    reg_rsp.rdata <= cdma_pkg::DATA_W'(len);
          cdma_pkg::REG_STATUS: reg_rsp.rdata <= cdma_pkg::DATA_W'(status);
          default: ;
        endcase
      end
    end
  end

endmodule

/* hw/copy_engine/copy_engine.sv */
/* copy_engine
   moves len words from src to dst, at most two reads ahead of the writes */
`timescale 1ns/1ns

module copy_engine (
  input  logic                         ap_clk,
  input  logic                         arst_n,
  input  logic                         start,
  input  cdma_pkg::gmem_addr_u         src,
  input  cdma_pkg::gmem_addr_u         dst,
  input  logic [cdma_pkg::LEN_W-1:0]   len,
  output cdma_pkg::mem_req_t           mem_req,
  output logic                         mem_req_valid,
  input  logic                         mem_req_ready,
  input  logic                         mem_rsp_valid,
  input  logic [cdma_pkg::DATA_W-1:0]  mem_rsp_data,
  output logic                         done
);

  cdma_pkg::gmem_addr_u             src_q;
  cdma_pkg::gmem_addr_u             dst_q;
  logic [cdma_pkg::LEN_W-1:0]       len_q;
  logic [cdma_pkg::LEN_W-1:0]       rd_idx;
  logic [cdma_pkg::LEN_W-1:0]       wr_idx;
  logic [cdma_pkg::DATA_W-1:0]      buf_mem [cdma_pkg::MAX_INFLIGHT];
  logic [cdma_pkg::INFL_PTR_W-1:0]  buf_wr;
  logic [cdma_pkg::INFL_PTR_W-1:0]  buf_rd;
  logic [cdma_pkg::INFL_W-1:0]      buf_cnt;
  logic [cdma_pkg::INFL_W-1:0]      rd_used;  // reads issued, not yet turned into writes
  logic                             active;
  logic                             req_last;
  logic                             req_fire;
  logic                             last_fire;
  logic                             can_load;
  logic                             load_wr;
  logic                             load_rd;

  assign req_fire  = mem_req_valid && mem_req_ready;
  assign last_fire = req_fire && mem_req.we && req_last;
  assign can_load  = !mem_req_valid || req_fire;  // request stage free next cycle
  assign load_wr   = can_load && (buf_cnt != '0);  // writes first
  assign load_rd   = can_load && !load_wr && active && (rd_idx != len_q) &&
                     (rd_used < cdma_pkg::INFL_W'(cdma_pkg::MAX_INFLIGHT));

  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      active        <= 1'b0;
      mem_req_valid <= 1'b0;
      done          <= 1'b0;
      rd_idx        <= '0;
      wr_idx        <= '0;
      rd_used       <= '0;
      buf_wr        <= '0;
      buf_rd        <= '0;
      buf_cnt       <= '0;
    end else begin
      done <= last_fire;
      if (start) begin
        active <= 1'b1;
        rd_idx <= '0;
        wr_idx <= '0;
      end else if (last_fire) begin
        active <= 1'b0;
      end
      if (can_load) begin
        mem_req_valid <= load_wr || load_rd;
      end
      if (load_rd) begin
        rd_idx <= rd_idx + 1'b1;
      end
      if (load_wr) begin
        wr_idx <= wr_idx + 1'b1;
        buf_rd <= buf_rd + 1'b1;
      end
      if (mem_rsp_valid) begin
        buf_wr <= buf_wr + 1'b1;
      end
      rd_used <= rd_used + cdma_pkg::INFL_W'(load_rd) - cdma_pkg::INFL_W'(load_wr);
      buf_cnt <= buf_cnt + cdma_pkg::INFL_W'(mem_rsp_valid) - cdma_pkg::INFL_W'(load_wr);
    end
  end

  always_ff @(posedge ap_clk) begin
    if (start) begin
      src_q <= src;
      dst_q <= dst;
      len_q <= len;
    end
    if (mem_rsp_valid) begin
      buf_mem[buf_wr] <= mem_rsp_data;
    end
    if (load_wr) begin
      mem_req.we        <= 1'b1;
      mem_req.addr.flat <= dst_q.flat + cdma_pkg::ADDR_W'(wr_idx);
      mem_req.wdata     <= buf_mem[buf_rd];
      req_last          <= (wr_idx == len_q - 1'b1);
    end else if (load_rd) begin
      mem_req.we        <= 1'b0;
      mem_req.addr.flat <= src_q.flat + cdma_pkg::ADDR_W'(rd_idx);
      mem_req.wdata     <= '0;
      req_last          <= 1'b0;
    end
  end

endmodule

/* hw/bank_router.sv */
/* bank_router
   steers engine requests to six banks and returns read data in issue order */
`timescale 1ns/1ns

module bank_router (
  input  logic                            ap_clk,
  input  logic                            arst_n,
  input  cdma_pkg::mem_req_t              mem_req,
  input  logic                            mem_req_valid,
  output logic                            mem_req_ready,
  output logic                            mem_rsp_valid,
  output logic [cdma_pkg::DATA_W-1:0]     mem_rsp_data,
  output cdma_pkg::bank_req_t             bank_req       [cdma_pkg::NUM_BANKS],
  output logic [cdma_pkg::NUM_BANKS-1:0]  bank_req_valid,
  input  logic [cdma_pkg::NUM_BANKS-1:0]  bank_req_ready,
  input  logic [cdma_pkg::NUM_BANKS-1:0]  bank_rsp_valid,
  input  logic [cdma_pkg::DATA_W-1:0]     bank_rsp_data  [cdma_pkg::NUM_BANKS],
  output logic [cdma_pkg::NUM_BANKS-1:0]  bank_rsp_ready
);

  logic [cdma_pkg::BANK_W-1:0]      sel;
  logic [cdma_pkg::BANK_W-1:0]      head;
  logic [cdma_pkg::BANK_W-1:0]      ord_q [cdma_pkg::MAX_INFLIGHT];  // banks of pending reads
  logic [cdma_pkg::INFL_PTR_W-1:0]  ord_wr;
  logic [cdma_pkg::INFL_PTR_W-1:0]  ord_rd;
  logic [cdma_pkg::INFL_W-1:0]      ord_cnt;
  logic                             rd_fire;

  assign sel     = mem_req.addr.split.bank;
  assign head    = ord_q[ord_rd];
  assign rd_fire = mem_req_valid && mem_req_ready && !mem_req.we;

  always_comb begin
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_data  = '0;
    for (int b = 0; b < cdma_pkg::NUM_BANKS; b++) begin
      bank_req[b].we     = mem_req.we;
      bank_req[b].ofs    = mem_req.addr.split.ofs;
      bank_req[b].wdata  = mem_req.wdata;
      bank_req_valid[b]  = mem_req_valid && (sel == cdma_pkg::BANK_W'(b));
      bank_rsp_ready[b]  = (ord_cnt != '0) && (head == cdma_pkg::BANK_W'(b));  // head only
      if (sel == cdma_pkg::BANK_W'(b)) begin
        mem_req_ready = bank_req_ready[b];
      end
      if (bank_rsp_ready[b]) begin
        mem_rsp_valid = bank_rsp_valid[b];
        mem_rsp_data  = bank_rsp_data[b];
      end
    end
  end

  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      ord_wr  <= '0;
      ord_rd  <= '0;
      ord_cnt <= '0;
    end else begin
      if (rd_fire) begin
        ord_wr <= ord_wr + 1'b1;
      end
      if (mem_rsp_valid) begin
        ord_rd <= ord_rd + 1'b1;
      end
      ord_cnt <= ord_cnt + cdma_pkg::INFL_W'(rd_fire) - cdma_pkg::INFL_W'(mem_rsp_valid);
    end
  end

  always_ff @(posedge ap_clk) begin
    if (rd_fire) begin
      ord_q[ord_wr] <= sel;
    end
  end

endmodule

/* hw/cdma_top.sv */
/* cdma top
   register slave, copy engine and six-bank router */
`timescale 1ns/1ns

module cdma_top (
  input  logic                                 ap_clk,
  input  logic                                 arst_n,
  input  cdma_pkg::reg_req_t                   reg_req,
  input  logic                                 reg_req_valid,
  output logic                                 reg_req_ready,
  output cdma_pkg::reg_rsp_t                   reg_rsp,
  output logic                                 reg_rsp_valid,
  input  logic                                 reg_rsp_ready,
  output cdma_pkg::bank_req_t                  bank_req       [cdma_pkg::NUM_BANKS],
  output logic [cdma_pkg::NUM_BANKS-1:0]       bank_req_valid,
  input  logic [cdma_pkg::NUM_BANKS-1:0]       bank_req_ready,
  input  logic [cdma_pkg::NUM_BANKS-1:0]       bank_rsp_valid,
  input  logic [cdma_pkg::DATA_W-1:0]          bank_rsp_data  [cdma_pkg::NUM_BANKS],
  output logic [cdma_pkg::NUM_BANKS-1:0]       bank_rsp_ready
);

  logic                         start;
  logic                         done;
  cdma_pkg::gmem_addr_u         src;
  cdma_pkg::gmem_addr_u         dst;
  logic [cdma_pkg::LEN_W-1:0]   len;
  cdma_pkg::mem_req_t           mem_req;
  logic                         mem_req_valid;
  logic                         mem_req_ready;
  logic                         mem_rsp_valid;
  logic [cdma_pkg::DATA_W-1:0]  mem_rsp_data;

  ctrl_regs i_ctrl_regs (
    .ap_clk        (ap_clk),
    .arst_n        (arst_n),
    .reg_req       (reg_req),
    .reg_req_valid (reg_req_valid),
    .reg_req_ready (reg_req_ready),
    .reg_rsp       (reg_rsp),
    .reg_rsp_valid (reg_rsp_valid),
    .reg_rsp_ready (reg_rsp_ready),
    .start         (start),
    .src           (src),
    .dst           (dst),
    .len           (len),
    .done          (done)
  );

  copy_engine i_copy_engine (
    .ap_clk        (ap_clk),
    .arst_n        (arst_n),
    .start         (start),
    .src           (src),
    .dst           (dst),
    .len           (len),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data),
    .done          (done)
  );

  bank_router i_bank_router (
    .ap_clk         (ap_clk),
    .arst_n         (arst_n),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_rsp_valid  (mem_rsp_valid),
    .mem_rsp_data   (mem_rsp_data),
    .bank_req       (bank_req),
    .bank_req_valid (bank_req_valid),
    .bank_req_ready (bank_req_ready),
    .bank_rsp_valid (bank_rsp_valid),
    .bank_rsp_data  (bank_rsp_data),
    .bank_rsp_ready (bank_rsp_ready)
  );

endmodule

/* bench/cdma_props.sv */
/* cdma_props
   handshake, bank select and done rules checked on the cdma top level */
`timescale 1ns/1ns

module cdma_props (
  input logic                              ap_clk,
  input logic                              arst_n,
  input cdma_pkg::reg_req_t                reg_req,
  input logic                              reg_req_valid,
  input logic                              reg_req_ready,
  input cdma_pkg::reg_rsp_t                reg_rsp,
  input logic                              reg_rsp_valid,
  input logic                              reg_rsp_ready,
  input cdma_pkg::mem_req_t                mem_req,
  input logic                              mem_req_valid,
  input logic                              mem_req_ready,
  input cdma_pkg::bank_req_t               bank_req       [cdma_pkg::NUM_BANKS],
  input logic [cdma_pkg::NUM_BANKS-1:0]    bank_req_valid,
  input logic [cdma_pkg::NUM_BANKS-1:0]    bank_req_ready,
  input logic [cdma_pkg::NUM_BANKS-1:0]    bank_rsp_valid,
  input logic [cdma_pkg::DATA_W-1:0]       bank_rsp_data  [cdma_pkg::NUM_BANKS],
  input logic [cdma_pkg::NUM_BANKS-1:0]    bank_rsp_ready,
  input logic                              done,
  input cdma_pkg::status_t                 status
);

  int unsigned fail_cnt = 0;  // read by the testbench

  one_bank: assert property (@(posedge ap_clk) disable iff (!arst_n) $onehot0(bank_req_valid))
    else begin $error("more than one bank request valid"); fail_cnt++; end

  req_hold: assert property (@(posedge ap_clk) disable iff (!arst_n)
    reg_req_valid && !reg_req_ready |=> reg_req_valid && $stable(reg_req))
    else begin $error("register request dropped or changed before ready"); fail_cnt++; end

  rsp_hold: assert property (@(posedge ap_clk) disable iff (!arst_n)
    reg_rsp_valid && !reg_rsp_ready |=> reg_rsp_valid && $stable(reg_rsp))
    else begin $error("register response dropped or changed before ready"); fail_cnt++; end

  mem_hold: assert property (@(posedge ap_clk) disable iff (!arst_n)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else begin $error("engine request dropped or changed before ready"); fail_cnt++; end

  for (genvar b = 0; b < cdma_pkg::NUM_BANKS; b++) begin : g_bank
    bank_req_hold: assert property (@(posedge ap_clk) disable iff (!arst_n)
      bank_req_valid[b] && !bank_req_ready[b] |=> bank_req_valid[b] && $stable(bank_req[b]))
      else begin $error("bank request dropped or changed before ready"); fail_cnt++; end

    bank_rsp_hold: assert property (@(posedge ap_clk) disable iff (!arst_n)
      bank_rsp_valid[b] && !bank_rsp_ready[b] |=> bank_rsp_valid[b] && $stable(bank_rsp_data[b]))
      else begin $error("bank response dropped or changed before ready"); fail_cnt++; end
  end

  done_busy: assert property (@(posedge ap_clk) disable iff (!arst_n) done |-> $past(status.busy))
    else begin $error("done pulse while the engine was not busy"); fail_cnt++; end

endmodule

/* bench/tb_cdma.sv */
/* tb_cdma
   testbench for the copy engine, with six bank models and a reference memory */
`timescale 1ns/1ns

module tb_cdma;

  localparam int MEM_WORDS   = cdma_pkg::NUM_BANKS << cdma_pkg::OFS_W;
  localparam int TEST_WORDS  = 16 + 40 + 16 + 24;
  localparam int CYCLE_LIMIT = 8 * TEST_WORDS + 2000;

  logic                              ap_clk = 1'b0;
  logic                              arst_n;
  cdma_pkg::reg_req_t                reg_req;
  logic                              reg_req_valid;
  logic                              reg_req_ready;
  cdma_pkg::reg_rsp_t                reg_rsp;
  logic                              reg_rsp_valid;
  logic                              reg_rsp_ready = 1'b1;
  cdma_pkg::bank_req_t               bank_req       [cdma_pkg::NUM_BANKS];
  logic [cdma_pkg::NUM_BANKS-1:0]    bank_req_valid;
  logic [cdma_pkg::NUM_BANKS-1:0]    bank_req_ready = '0;
  logic [cdma_pkg::NUM_BANKS-1:0]    bank_rsp_valid = '0;
  logic [cdma_pkg::DATA_W-1:0]       bank_rsp_data  [cdma_pkg::NUM_BANKS] = '{default: '0};
  logic [cdma_pkg::NUM_BANKS-1:0]    bank_rsp_ready;

  logic [31:0]          mem      [MEM_WORDS];
  logic [31:0]          ref_mem  [MEM_WORDS];  // expected memory contents
  logic [31:0]          pend     [cdma_pkg::NUM_BANKS][4];  // read data waiting per bank
  int                   pend_cnt [cdma_pkg::NUM_BANKS] = '{default: 0};
  int                   rsp_wait [cdma_pkg::NUM_BANKS] = '{default: 0};
  logic [5:0]           req_hit = '0;
  logic [5:0]           rsp_hit = '0;
  cdma_pkg::bank_req_t  req_snap [cdma_pkg::NUM_BANKS];
  bit                   stall_en;
  int                   win_lo, win_len;  // legal write window
  int                   cycles = 0, access_count = 0, wr_count = 0, stray_writes = 0;
  int                   errors = 0, err_base = 0, passed = 0, failed = 0;

  cdma_top i_cdma_top (.*);

  bind cdma_top cdma_props i_cdma_props (
    .ap_clk(ap_clk), .arst_n(arst_n), .reg_req(reg_req), .reg_req_valid(reg_req_valid),
    .reg_req_ready(reg_req_ready), .reg_rsp(reg_rsp), .reg_rsp_valid(reg_rsp_valid),
    .reg_rsp_ready(reg_rsp_ready), .mem_req(mem_req), .mem_req_valid(mem_req_valid),
    .mem_req_ready(mem_req_ready), .bank_req(bank_req), .bank_req_valid(bank_req_valid),
    .bank_req_ready(bank_req_ready), .bank_rsp_valid(bank_rsp_valid),
    .bank_rsp_data(bank_rsp_data), .bank_rsp_ready(bank_rsp_ready), .done(done),
    .status(i_ctrl_regs.status)
  );

  always #2 ap_clk = ~ap_clk;

  always @(posedge ap_clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, a copy or register access never finished", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  // host stalls register responses at random
  always @(negedge ap_clk) begin
    reg_rsp_ready = ($urandom % 3) != 0;
  end

  // bank models apply last edge's transfers, drive, then sample before the next edge
  always @(negedge ap_clk) begin
    int a;
    for (int b = 0; b < cdma_pkg::NUM_BANKS; b++) begin
      a = (b << cdma_pkg::OFS_W) + int'(req_snap[b].ofs);
      if (req_hit[b]) begin
        access_count++;
        if (req_snap[b].we) begin
          mem[a] = req_snap[b].wdata;
          wr_count++;
          assert (a >= win_lo && a < win_lo + win_len) else begin
            $display("bank %0d written outside the destination range at word %h", b, a);
            stray_writes++;
          end
        end else begin
          if (pend_cnt[b] == 0) rsp_wait[b] = $urandom % 4;
          pend[b][pend_cnt[b]] = mem[a];
          pend_cnt[b]++;
        end
      end
      if (rsp_hit[b]) begin
        for (int k = 0; k < 3; k++) pend[b][k] = pend[b][k+1];
        pend_cnt[b]--;
        rsp_wait[b] = $urandom % 4;  // delay of the next response
      end
      bank_req_ready[b] = stall_en ? ($urandom % 4 != 0) : 1'b1;
      if (!bank_rsp_valid[b] || rsp_hit[b]) begin  // otherwise hold
        bank_rsp_valid[b] = 1'b0;
        if (pend_cnt[b] > 0 && rsp_wait[b] == 0) begin
          bank_rsp_valid[b] = 1'b1;
          bank_rsp_data[b]  = pend[b][0];
        end else if (pend_cnt[b] > 0) begin
          rsp_wait[b]--;
        end
      end
    end
    #1;
    for (int b = 0; b < cdma_pkg::NUM_BANKS; b++) begin
      req_hit[b]  = bank_req_valid[b] && bank_req_ready[b];
      rsp_hit[b]  = bank_rsp_valid[b] && bank_rsp_ready[b];
      req_snap[b] = bank_req[b];
    end
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic reg_access(input logic we, input logic [cdma_pkg::REG_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge ap_clk);
    reg_req       = '{we: we, addr: addr, wdata: wdata};
    reg_req_valid = 1'b1;
    #1;
    while (!reg_req_ready) begin
      @(negedge ap_clk);
      #1;
    end
    @(negedge ap_clk);
    reg_req_valid = 1'b0;
    #1;
    while (!reg_rsp_valid) begin
      @(negedge ap_clk);
      #1;
    end
    rdata = reg_rsp.rdata;
  endtask

  task automatic reg_write(input logic [cdma_pkg::REG_ADDR_W-1:0] addr, input logic [31:0] d);
    logic [31:0] unused;
    reg_access(1'b1, addr, d, unused);
  endtask

  task automatic reg_read(input logic [cdma_pkg::REG_ADDR_W-1:0] addr, output logic [31:0] d);
    reg_access(1'b0, addr, '0, d);
  endtask

  task automatic compare_memory();
    for (int a = 0; a < MEM_WORDS; a++) begin
      if (mem[a] !== ref_mem[a]) begin
        check_eq($sformatf("mem[%h]", a), mem[a], ref_mem[a]);  // first mismatch only
        break;
      end
    end
  endtask

  task automatic run_copy(input logic [15:0] src, input logic [15:0] dst, input int len,
                          input bit restart);
    logic [31:0] st;
    int          wr_base;
    wr_base = wr_count;
    win_lo  = int'(dst);
    win_len = len;
    reg_write(cdma_pkg::REG_SRC, 32'(src));
    reg_write(cdma_pkg::REG_DST, 32'(dst));
    reg_write(cdma_pkg::REG_LEN, 32'(len));
    for (int i = 0; i < len; i++) ref_mem[int'(dst) + i] = ref_mem[int'(src) + i];
    reg_write(cdma_pkg::REG_CTRL, 32'h1);
    if (restart) begin
      reg_write(cdma_pkg::REG_CTRL, 32'h1);  // must be ignored
      reg_read(cdma_pkg::REG_STATUS, st);
      check_eq("status.busy", 32'(st[2]), 32'h1);
    end
    st = '0;
    while (!st[1]) reg_read(cdma_pkg::REG_STATUS, st);
    check_eq("status", st, 32'h2);
    check_eq("bank write count", 32'(wr_count - wr_base), 32'(len));
    compare_memory();
  endtask

  task automatic finish_test(input string name);
    int n;
    n = errors + stray_writes + int'(i_cdma_top.i_cdma_props.fail_cnt) - err_base;
    err_base += n;
    if (n == 0) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", name, n);
    end
  endtask

  initial begin
    logic [31:0] st;
    int          acc_base;
    void'($urandom(76732));
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a]     = $urandom;
      ref_mem[a] = mem[a];
    end
    arst_n = 1'b0;
    reg_req = '0;
    reg_req_valid = 1'b0;
    stall_en = 1'b0;
    win_lo = 0;
    win_len = 0;
    repeat (16) @(posedge ap_clk);
    @(negedge ap_clk);
    arst_n = 1'b1;

    reg_read(cdma_pkg::REG_STATUS, st);
    check_eq("status", st, 32'h0);
    reg_write(cdma_pkg::REG_SRC, 32'h1234);
    reg_write(cdma_pkg::REG_DST, 32'h5678);
    reg_write(cdma_pkg::REG_LEN, 32'h0abc);
    reg_read(cdma_pkg::REG_SRC, st);
    check_eq("src", st, 32'h1234);
    reg_read(cdma_pkg::REG_DST, st);
    check_eq("dst", st, 32'h5678);
    reg_read(cdma_pkg::REG_LEN, st);
    check_eq("len", st, 32'h0abc);
    finish_test("register readback");

    run_copy(16'h2010, 16'h2100, 16, 1'b0);  // bank 1 only
    finish_test("single-bank copy");

    stall_en = 1'b1;
    run_copy(16'h5ff0, 16'ha020, 40, 1'b0);  // source crosses bank 2 into bank 3
    finish_test("cross-bank copy");

    acc_base = access_count;
    win_len  = 0;
    reg_write(cdma_pkg::REG_SRC, 32'h0100);
    reg_write(cdma_pkg::REG_DST, 32'hbff8);  // last word lands in bank 6
    reg_write(cdma_pkg::REG_LEN, 32'd16);
    reg_write(cdma_pkg::REG_CTRL, 32'h1);
    reg_read(cdma_pkg::REG_STATUS, st);
    check_eq("status", st, 32'h1);
    repeat (20) @(negedge ap_clk);
    check_eq("bank access count", 32'(access_count - acc_base), 32'h0);
    finish_test("illegal range");

    run_copy(16'h0200, 16'h8300, 24, 1'b1);
    finish_test("start while busy");

    $display("tests passed %0d, failed %0d", passed, failed);
    if (failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
common/cdma_pkg.sv
hw/ctrl_regs/ctrl_regs.sv
hw/copy_engine/copy_engine.sv
hw/bank_router.sv
hw/cdma_top.sv
bench/cdma_props.sv
bench/tb_cdma.sv

/* Makefile */
# Verilator build and run for the cdma testbench

VERILATOR ?= verilator
TOP       ?= tb_cdma
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) $(RUN_ARGS) | tee $(LOG)
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
